// ==== files.f ====
hw/cmdPkg.sv
hw/apbCmdWriter.sv
hw/cmdMem.sv
hw/outSlot.sv
hw/cmdParser.sv
hw/cmdTop.sv
verification/cmdTb.sv

// ==== Makefile ====
TOP = cmdTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f files.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "sim passed"

clean:
	rm -rf obj_dir

// ==== verification/cmdTb.sv ====
`timescale 1ns/1ps

module cmdTb;

    logic                           clk;
    logic                           rstN;
    logic                           psel;
    logic                           penable;
    logic                           pwrite;
    logic [cmdPkg::apbAddrBits-1:0] paddr;
    cmdPkg::cmdWord                 pwdata;
    cmdPkg::cmdWord                 prdata;
    logic                           pready;
    logic                           pslverr;
    logic                           vtxValid;
    logic                           vtxReady = 1'b1;  // Owned by the ready driver
    cmdPkg::vertexPkt               vtx;
    logic                           rowValid;
    logic                           rowReady = 1'b1;
    cmdPkg::matrixRow               row;

    logic [31:0]         lfsr      = 32'h8bb0;  // Stimulus stream
    logic [31:0]         stallLfsr = 32'h8bb0;  // Ready stream, separate state
    int                  readyMode = 0;         // 0 ready, 1 random, 2 stalled
    int                  errors    = 0;
    int                  checks    = 0;
    int                  testErrs  = 0;
    cmdPkg::cmdWord      listQ[$];              // List under test
    cmdPkg::vertexPkt    expVtx[$];             // Predicted vertex stream
    cmdPkg::matrixRow    expRow[$];             // Predicted row stream
    cmdPkg::parserStatus expStatus;
    logic [7:0]          mMode = '0;            // Model color and mode
    cmdPkg::cmdWord      mR = '0;
    cmdPkg::cmdWord      mG = '0;
    cmdPkg::cmdWord      mB = '0;
    logic                vtxHeld = 1'b0;        // Stalled last cycle
    logic                rowHeld = 1'b0;
    cmdPkg::vertexPkt    vtxLast;
    cmdPkg::matrixRow    rowLast;

    cmdTop dut (
        .clk, .rstN, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
        .pready, .pslverr, .vtxValid, .vtxReady, .vtx, .rowValid, .rowReady, .row
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    ////////////////////////////////////////////////////////////
    // Random numbers
    ////////////////////////////////////////////////////////////

    // Taps 32 22 2 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        int          k;
        v = '0;
        for (k = 0; k < n; k++) begin
            lfsr = lfsrStep(lfsr);  // One step per bit
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    always @(negedge clk) begin
        case (readyMode)
            0: begin
                vtxReady = 1'b1;
                rowReady = 1'b1;
            end
            1: begin
                stallLfsr = lfsrStep(stallLfsr);
                vtxReady  = stallLfsr[0];
                stallLfsr = lfsrStep(stallLfsr);
                rowReady  = stallLfsr[0];
            end
            default: begin
                vtxReady = 1'b0;  // Hold both streams
                rowReady = 1'b0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic checkVertex(input cmdPkg::vertexPkt got, input cmdPkg::vertexPkt exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkRow(input cmdPkg::matrixRow got, input cmdPkg::matrixRow exp,
                            input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkStatus(input cmdPkg::parserStatus got,
                               input cmdPkg::parserStatus exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic checkErr(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s pslverr %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic checkReady(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s pready %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic noteProblem(input string what);
        errors++;
        $display("%s at %0t", what, $time);
    endtask

    ////////////////////////////////////////////////////////////
    // Stream monitors
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rstN) begin
            if (vtxHeld && !vtxValid) noteProblem("vertex valid dropped while stalled");
            else if (vtxHeld) checkVertex(vtx, vtxLast, "stalled vertex");
            if (vtxValid && vtxReady) begin
                if (expVtx.size() == 0) noteProblem("unexpected vertex packet");
                else checkVertex(vtx, expVtx.pop_front(), "vertex packet");
            end
            vtxHeld = vtxValid && !vtxReady;
            vtxLast = vtx;
        end
    end

    always @(posedge clk) begin
        if (rstN) begin
            if (rowHeld && !rowValid) noteProblem("row valid dropped while stalled");
            else if (rowHeld) checkRow(row, rowLast, "stalled row");
            if (rowValid && rowReady) begin
                if (expRow.size() == 0) noteProblem("unexpected matrix row");
                else checkRow(row, expRow.pop_front(), "matrix row");
            end
            rowHeld = rowValid && !rowReady;
            rowLast = row;
        end
    end

    ////////////////////////////////////////////////////////////
    // APB access
    ////////////////////////////////////////////////////////////

    task automatic apbWrite(input logic [11:0] addr, input cmdPkg::cmdWord data,
                            output logic err);
        @(negedge clk);
        psel    = 1'b1;  // Setup phase
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;  // Access phase, no wait states
        @(posedge clk);
        err = pslverr;
        checkReady(pready, 1'b1, "write access");
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apbRead(input logic [11:0] addr, output cmdPkg::cmdWord data,
                           output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        data = prdata;
        err  = pslverr;
        checkReady(pready, 1'b1, "read access");
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    function automatic logic [11:0] storeByteAddr(input cmdPkg::cmdAddr a);
        return {4'h0, a, 2'b00};
    endfunction

    ////////////////////////////////////////////////////////////
    // List building and model
    ////////////////////////////////////////////////////////////

    task automatic addCmd(input logic [7:0] op, input int nArgs);
        cmdPkg::cmdHeader h;
        logic [31:0]      r;
        int               k;
        r         = randBits(8);
        h.hasArgs = (nArgs != 0);
        h.reserved = '0;
        h.imm     = r[7:0];  // Only matrix mode uses it
        h.opcode  = op;
        listQ.push_back(cmdPkg::cmdWord'(h));
        for (k = 0; k < nArgs; k++) listQ.push_back(randBits(32));
    endtask

    // Random mix that always fits the store
    task automatic genList();
        int          n;
        int          cmds;
        logic [31:0] r;
        listQ.delete();
        cmds = 1 + int'(randBits(3));
        for (n = 0; n < cmds; n++) begin
            r = randBits(2);
            if (r[1:0] == 2'd3 && listQ.size() + 17 <= 50) addCmd(cmdPkg::opLoadMatrix, 16);
            else if (r[1:0] == 2'd0 && listQ.size() + 4 <= 50) addCmd(cmdPkg::opColor, 3);
            else if (r[1:0] == 2'd1 && listQ.size() + 4 <= 50) addCmd(cmdPkg::opVertex, 3);
            else addCmd(cmdPkg::opMatrixMode, 0);
        end
        addCmd(cmdPkg::opEnd, 0);
    endtask

    // Walks listQ by opcode, argument count from the opcode alone
    task automatic predictList();
        int               i;
        int               k;
        logic             stop;
        cmdPkg::cmdHeader h;
        cmdPkg::vertexPkt v;
        cmdPkg::matrixRow r;
        i    = 0;
        stop = 1'b0;
        while (!stop && i < listQ.size()) begin
            h = cmdPkg::cmdHeader'(listQ[i]);
            case (h.opcode)
                cmdPkg::opMatrixMode: begin
                    mMode = h.imm;
                    i     = i + 1;
                end
                cmdPkg::opColor: begin
                    mR = listQ[i+1];
                    mG = listQ[i+2];
                    mB = listQ[i+3];
                    i  = i + 4;
                end
                cmdPkg::opVertex: begin
                    v = '{mode: mMode, r: mR, g: mG, b: mB,
                          x: listQ[i+1], y: listQ[i+2], z: listQ[i+3]};
                    expVtx.push_back(v);
                    i = i + 4;
                end
                cmdPkg::opLoadMatrix: begin
                    for (k = 0; k < 4; k++) begin
                        r = '{mode: mMode, row: k[1:0], c0: listQ[i+1+4*k],
                              c1: listQ[i+2+4*k], c2: listQ[i+3+4*k], c3: listQ[i+4+4*k]};
                        expRow.push_back(r);
                    end
                    i = i + 17;
                end
                cmdPkg::opEnd: begin
                    expStatus = '{busy: 1'b0, done: 1'b1, error: 1'b0};
                    stop      = 1'b1;
                end
                default: begin
                    expStatus = '{busy: 1'b0, done: 1'b0, error: 1'b1};  // Stops here
                    stop      = 1'b1;
                end
            endcase
        end
    endtask

    ////////////////////////////////////////////////////////////
    // List run steps
    ////////////////////////////////////////////////////////////

    task automatic loadList(input cmdPkg::cmdAddr at);
        logic err;
        int   i;
        for (i = 0; i < listQ.size(); i++) begin
            apbWrite(storeByteAddr(cmdPkg::cmdAddr'(at + i)), listQ[i], err);  // Wraps
            checkErr(err, 1'b0, "store write");
        end
    endtask

    task automatic startList(input cmdPkg::cmdAddr at);
        logic err;
        apbWrite(cmdPkg::regCtrl, cmdPkg::cmdWord'(at), err);
        checkErr(err, 1'b0, "ctrl write");
    endtask

    task automatic finishList(input string what);
        cmdPkg::cmdWord data;
        logic           err;
        int             n;
        n = 0;
        do begin
            apbRead(cmdPkg::regStatus, data, err);
            n++;
        end while (data[2] && n < 500);  // Busy bit
        if (data[2]) noteProblem({"timeout waiting for list end in ", what});
        checkStatus(cmdPkg::parserStatus'(data[2:0]), expStatus, what);
        n = 0;
        while ((expVtx.size() != 0 || expRow.size() != 0 || vtxValid || rowValid)
               && n < 2000) begin
            @(negedge clk);
            n++;
        end
        if (n >= 2000) noteProblem({"timeout waiting for streams to drain in ", what});
    endtask

    task automatic runList(input cmdPkg::cmdAddr at, input string what);
        loadList(at);
        predictList();
        startList(at);
        finishList(what);
    endtask

    task automatic endTest(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, errors - testErrs);
        testErrs = errors;
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    initial begin
        cmdPkg::cmdWord data;
        logic           err;
        int             n;
        int             rep;
        logic [31:0]    r;
        cmdPkg::cmdAddr at;
        rstN    = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        // Reset values and bad accesses
        apbRead(cmdPkg::regStatus, data, err);
        checkErr(err, 1'b0, "status read");
        checkStatus(cmdPkg::parserStatus'(data[2:0]), '0, "status after reset");
        apbRead(cmdPkg::regCtrl, data, err);
        checkErr(err, 1'b1, "ctrl read");
        apbWrite(12'h200, 32'h1234, err);
        checkErr(err, 1'b1, "write to 0x200");
        endTest(1, "reset and decode");

        // Vertices only, then the reference sequence
        listQ.delete();
        for (n = 0; n < 3; n++) addCmd(cmdPkg::opVertex, 3);
        addCmd(cmdPkg::opEnd, 0);
        runList(6'd0, "vertex list");
        listQ.delete();
        addCmd(cmdPkg::opMatrixMode, 0);
        addCmd(cmdPkg::opMatrixMode, 0);
        addCmd(cmdPkg::opLoadMatrix, 16);
        addCmd(cmdPkg::opColor, 3);
        addCmd(cmdPkg::opVertex, 3);
        addCmd(cmdPkg::opMatrixMode, 0);
        addCmd(cmdPkg::opEnd, 0);
        runList(6'd12, "reference list");
        endTest(2, "directed lists");

        // Random lists, every fourth one wraps past the top
        for (n = 0; n < 20; n++) begin
            genList();
            r  = randBits(6);
            at = (n % 4 == 3) ? 6'd60 : r[5:0];
            runList(at, "random list");
        end
        endTest(3, "random lists");

        // Same lists twice with random back-pressure
        readyMode = 1;
        for (n = 0; n < 6; n++) begin
            genList();
            r  = randBits(6);
            at = r[5:0];
            for (rep = 0; rep < 2; rep++) runList(at, "stalled list");
        end
        readyMode = 0;
        endTest(4, "back-pressure");

        // Unknown opcode in the middle
        listQ.delete();
        addCmd(cmdPkg::opColor, 3);
        addCmd(cmdPkg::opVertex, 3);
        addCmd(8'h55, 0);
        addCmd(cmdPkg::opVertex, 3);
        addCmd(cmdPkg::opEnd, 0);
        runList(6'd40, "unknown opcode list");
        endTest(5, "unknown opcode");

        // Host writes while busy, parser held on a full slot
        listQ.delete();
        for (n = 0; n < 3; n++) addCmd(cmdPkg::opVertex, 3);
        addCmd(cmdPkg::opEnd, 0);
        loadList(6'd20);
        predictList();
        readyMode = 2;
        startList(6'd20);
        n = 0;
        while (!vtxValid && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (!vtxValid) noteProblem("timeout waiting for a held vertex");
        apbWrite(storeByteAddr(6'd29), ~listQ[9], err);  // Third vertex x
        checkErr(err, 1'b1, "store write while busy");
        apbWrite(cmdPkg::regCtrl, 32'h0, err);
        checkErr(err, 1'b1, "ctrl write while busy");
        readyMode = 0;
        finishList("busy writes list");
        endTest(6, "writes while busy");

        $display("tests 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== hw/cmdTop.sv ====
`timescale 1ns/1ps

module cmdTop (
    input  logic                           clk,
    input  logic                           rstN,
    // APB slave
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [cmdPkg::apbAddrBits-1:0] paddr,
    input  cmdPkg::cmdWord                 pwdata,
    output cmdPkg::cmdWord                 prdata,
    output logic                           pready,
    output logic                           pslverr,
    // Vertex stream
    output logic                           vtxValid,
    input  logic                           vtxReady,
    output cmdPkg::vertexPkt               vtx,
    // Matrix row stream
    output logic                           rowValid,
    input  logic                           rowReady,
    output cmdPkg::matrixRow               row
);

    cmdPkg::parserStatus status;
    cmdPkg::memWrite     memWr;
    logic                start;
    cmdPkg::cmdAddr      startAddr;
    cmdPkg::cmdAddr      wordAddr;
    cmdPkg::cmdAddr      quadAddr;
    cmdPkg::cmdWord      word;
    cmdPkg::quadRead     quad;
    logic                vtxPush;
    logic                rowPush;
    logic                vtxFull;
    logic                rowFull;
    cmdPkg::vertexPkt    vtxData;
    cmdPkg::matrixRow    rowData;

    ////////////////////////////////////////////////////////////
    // Producer, buffer, consumer
    ////////////////////////////////////////////////////////////

    apbCmdWriter writer (
        .clk, .rstN, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr, .status, .memWr, .start, .startAddr
    );

    cmdMem store (
        .clk, .memWr, .wordAddr, .quadAddr, .word, .quad
    );

    cmdParser parser (
        .clk, .rstN, .start, .startAddr, .wordAddr, .quadAddr, .word, .quad,
        .vtxPush, .rowPush, .vtxFull, .rowFull, .vtxData, .rowData, .status
    );

    // Output slots, one per stream
    outSlot #(.payloadT(cmdPkg::vertexPkt)) vtxSlot (
        .clk, .rstN, .push(vtxPush), .inData(vtxData), .full(vtxFull),
        .valid(vtxValid), .ready(vtxReady), .outData(vtx)
    );

    outSlot #(.payloadT(cmdPkg::matrixRow)) rowSlot (
        .clk, .rstN, .push(rowPush), .inData(rowData), .full(rowFull),
        .valid(rowValid), .ready(rowReady), .outData(row)
    );

endmodule

// ==== hw/cmdParser.sv ====
`timescale 1ns/1ps

module cmdParser (
    input  logic                clk,
    input  logic                rstN,
    input  logic                start,
    input  cmdPkg::cmdAddr      startAddr,
    output cmdPkg::cmdAddr      wordAddr,
    output cmdPkg::cmdAddr      quadAddr,
    input  cmdPkg::cmdWord      word,
    input  cmdPkg::quadRead     quad,
    output logic                vtxPush,
    output logic                rowPush,
    input  logic                vtxFull,
    input  logic                rowFull,
    output cmdPkg::vertexPkt    vtxData,
    output cmdPkg::matrixRow    rowData,
    output cmdPkg::parserStatus status
);

    typedef enum logic [1:0] {
        stIdle,    // Waiting for start
        stHeader,  // Decode word at pc
        stArgs,    // Color or vertex arguments
        stRows     // Load matrix, one row per cycle
    } stateT;

    stateT            state;
    cmdPkg::cmdAddr   pc;      // Header address
    logic [7:0]       opReg;   // Opcode of the command in flight
    logic [1:0]       rowIdx;  // Matrix row being sent
    logic [7:0]       mode;    // Current matrix mode
    cmdPkg::cmdWord   colR;    // Current color
    cmdPkg::cmdWord   colG;
    cmdPkg::cmdWord   colB;
    cmdPkg::cmdHeader hdr;
    cmdPkg::cmdAddr   nextPc;  // Header after the current command

    assign hdr    = cmdPkg::cmdHeader'(word);
    assign nextPc = pc + cmdPkg::cmdAddr'(cmdPkg::argCount(opReg) + 5'd1);

    ////////////////////////////////////////////////////////////
    // Store addresses
    ////////////////////////////////////////////////////////////

    assign wordAddr = pc;
    assign quadAddr = pc + cmdPkg::cmdAddr'({rowIdx, 2'b01}); // pc + 1 + 4*row

    ////////////////////////////////////////////////////////////
    // Output packets
    ////////////////////////////////////////////////////////////

    assign vtxPush = (state == stArgs) && (opReg == cmdPkg::opVertex) && !vtxFull;
    assign rowPush = (state == stRows) && !rowFull;

    always_comb begin
        vtxData.mode = mode;
        vtxData.r    = colR;
        vtxData.g    = colG;
        vtxData.b    = colB;
        vtxData.x    = quad.w0;  // Arguments straight from the store
        vtxData.y    = quad.w1;
        vtxData.z    = quad.w2;
    end

    always_comb begin
        rowData.mode = mode;
        rowData.row  = rowIdx;
        rowData.c0   = quad.w0;
        rowData.c1   = quad.w1;
        rowData.c2   = quad.w2;
        rowData.c3   = quad.w3;
    end

    ////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state  <= stIdle;
            pc     <= '0;
            opReg  <= '0;
            rowIdx <= '0;
            mode   <= '0;
            colR   <= '0;
            colG   <= '0;
            colB   <= '0;
            status <= '0;
        end else begin
            case (state)
                stIdle: begin
                    if (start) begin
                        state  <= stHeader;
                        pc     <= startAddr;
                        status <= '{busy: 1'b1, done: 1'b0, error: 1'b0};
                    end
                end
                stHeader: begin
                    opReg  <= hdr.opcode;
                    rowIdx <= '0;
                    case (hdr.opcode)
                        cmdPkg::opMatrixMode: begin
                            mode <= hdr.imm;                   // Whole command here
                            pc   <= pc + cmdPkg::cmdAddr'(1);
                        end
                        cmdPkg::opColor,
                        cmdPkg::opVertex:     state <= stArgs;
                        cmdPkg::opLoadMatrix: state <= stRows;
                        cmdPkg::opEnd: begin
                            state       <= stIdle;
                            status.busy <= 1'b0;
                            status.done <= 1'b1;
                        end
                        default: begin
                            state        <= stIdle;             // Unknown opcode
                            status.busy  <= 1'b0;
                            status.error <= 1'b1;
                        end
                    endcase
                end
                stArgs: begin
                    if (opReg == cmdPkg::opColor) begin
                        colR  <= quad.w0;
                        colG  <= quad.w1;
                        colB  <= quad.w2;
                        pc    <= nextPc;
                        state <= stHeader;
                    end else if (!vtxFull) begin
                        pc    <= nextPc;  // Vertex pushed this cycle
                        state <= stHeader;
                    end
                end
                stRows: begin
                    if (!rowFull) begin
                        rowIdx <= rowIdx + 2'd1;
                        if (rowIdx == 2'd3) begin
                            pc    <= nextPc;  // Past all 16 words
                            state <= stHeader;
                        end
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    // Full slot holds the parser in place until it drains
    vtxNoOverrun: assert property (
        @(posedge clk) disable iff (!rstN)
        (state == stArgs) && (opReg == cmdPkg::opVertex) && vtxFull
            |=> (state == stArgs) && $stable(pc)
    ) else $error("parser moved past a vertex held by a full slot");

    rowNoOverrun: assert property (
        @(posedge clk) disable iff (!rstN)
        (state == stRows) && rowFull
            |=> (state == stRows) && $stable(rowIdx) && $stable(pc)
    ) else $error("parser moved past a row held by a full slot");

    // Writer blocks ctrl writes while busy
    noStartWhileBusy: assert property (
        @(posedge clk) disable iff (!rstN) start |-> !status.busy
    ) else $error("start seen while a list runs");

endmodule

// ==== hw/outSlot.sv ====
`timescale 1ns/1ps

module outSlot #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    push,
    input  payloadT inData,
    output logic    full,
    output logic    valid,
    input  logic    ready,
    output payloadT outData
);

    // Held entry with no pop this cycle
    assign full = valid && !ready;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            valid <= 1'b0;
        end else if (push) begin
            valid <= 1'b1;   // Refill, possibly while draining
        end else if (ready) begin
            valid <= 1'b0;   // Drained
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            outData <= inData;
        end
    end

    // Stalled output must hold its packet
    holdWhileStalled: assert property (
        @(posedge clk) disable iff (!rstN)
        valid && !ready |=> valid && $stable(outData)
    ) else $error("slot output changed while stalled");

endmodule

// ==== hw/cmdMem.sv ====
`timescale 1ns/1ps

module cmdMem (
    input  logic             clk,
    input  cmdPkg::memWrite  memWr,
    input  cmdPkg::cmdAddr   wordAddr,
    input  cmdPkg::cmdAddr   quadAddr,
    output cmdPkg::cmdWord   word,
    output cmdPkg::quadRead  quad
);

    cmdPkg::cmdWord mem [cmdPkg::cmdDepth];  // Command list words

    cmdPkg::cmdAddr quadAddr1;
    cmdPkg::cmdAddr quadAddr2;
    cmdPkg::cmdAddr quadAddr3;

    ////////////////////////////////////////////////////////////
    // Write port
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (memWr.en) begin
            mem[memWr.addr] <= memWr.data;  // Host writes land on the edge
        end
    end

    ////////////////////////////////////////////////////////////
    // Read ports, both combinational
    ////////////////////////////////////////////////////////////

    // Header fetch
    assign word = mem[wordAddr];

    // Six bit sums wrap past the top of the store
    assign quadAddr1 = quadAddr + cmdPkg::cmdAddr'(1);
    assign quadAddr2 = quadAddr + cmdPkg::cmdAddr'(2);
    assign quadAddr3 = quadAddr + cmdPkg::cmdAddr'(3);

    // Argument fetch, four words per cycle
    assign quad.w0 = mem[quadAddr];
    assign quad.w1 = mem[quadAddr1];
    assign quad.w2 = mem[quadAddr2];
    assign quad.w3 = mem[quadAddr3];

endmodule

// ==== hw/apbCmdWriter.sv ====
`timescale 1ns/1ps

module apbCmdWriter (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [cmdPkg::apbAddrBits-1:0]      paddr,
    input  cmdPkg::cmdWord                      pwdata,
    output cmdPkg::cmdWord                      prdata,
    output logic                                pready,
    output logic                                pslverr,
    input  cmdPkg::parserStatus                 status,
    output cmdPkg::memWrite                     memWr,
    output logic                                start,
    output cmdPkg::cmdAddr                      startAddr
);

    logic access;    // APB access phase
    logic inStore;   // Aligned word inside 0x000..0x0FC
    logic isCtrl;
    logic isStatus;
    logic wrOk;      // Host write allowed this cycle

    ////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////

    assign access   = psel && penable;
    assign inStore  = (paddr[11:8] == 4'h0) && (paddr[1:0] == 2'b00);
    assign isCtrl   = (paddr == cmdPkg::regCtrl);
    assign isStatus = (paddr == cmdPkg::regStatus);

    assign wrOk = access && pwrite && !status.busy; // Single busy gate

    // Zero wait states
    assign pready = 1'b1;

    // Error cases, only in the access phase
    always_comb begin
        pslverr = 1'b0;
        if (access) begin
            if (!pwrite) begin
                pslverr = !isStatus;            // Only status reads back
            end else if (inStore || isCtrl) begin
                pslverr = status.busy;          // No edits while a list runs
            end else begin
                pslverr = 1'b1;                 // Undefined, status included
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Store write and list start
    ////////////////////////////////////////////////////////////

    assign memWr.en   = wrOk && inStore;
    assign memWr.addr = paddr[7:2];  // Byte to word address
    assign memWr.data = pwdata;

    assign start     = wrOk && isCtrl;               // One cycle pulse
    assign startAddr = cmdPkg::cmdAddr'(pwdata);     // pwdata[5:0]

    // Read data captured in the setup phase, ready for the access phase
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            prdata <= '0;
        end else if (psel && !penable) begin
            prdata <= isStatus ? cmdPkg::cmdWord'(status) : '0;
        end
    end

    // Host side protocol
    apbEnableNeedsSel: assert property (
        @(posedge clk) disable iff (!rstN) penable |-> psel
    ) else $error("penable high without psel");

endmodule

// ==== hw/cmdPkg.sv ====
package cmdPkg;

    ////////////////////////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////////////////////////

    localparam int cmdWordBits = 32;               // Command and argument word
    localparam int cmdDepth    = 64;               // Store depth in words
    localparam int cmdAddrBits = $clog2(cmdDepth); // Word address width
    localparam int apbAddrBits = 12;               // APB byte address width

    typedef logic [cmdWordBits-1:0] cmdWord;
    typedef logic [cmdAddrBits-1:0] cmdAddr;

    // Opcodes in header bits 7:0
    localparam logic [7:0] opEnd        = 8'h00;
    localparam logic [7:0] opVertex     = 8'h03;
    localparam logic [7:0] opColor      = 8'h04;
    localparam logic [7:0] opMatrixMode = 8'h10;
    localparam logic [7:0] opLoadMatrix = 8'h16;

    // APB register map, store sits at 0x000..0x0FC
    localparam logic [apbAddrBits-1:0] regCtrl   = 12'h100;
    localparam logic [apbAddrBits-1:0] regStatus = 12'h104;

    // Argument words per opcode; header bit 31 is not trusted
    function automatic logic [4:0] argCount(input logic [7:0] opcode);
        case (opcode)
            opColor,
            opVertex:     return 5'd3;  // r g b or x y z
            opLoadMatrix: return 5'd16; // Four rows of four
            default:      return 5'd0;  // End, mode and unknown
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Packed structs
    ////////////////////////////////////////////////////////////

    // Command header layout
    typedef struct packed {
        logic        hasArgs;  // Bit 31, argument words follow
        logic [14:0] reserved;
        logic [7:0]  imm;      // Immediate, mode for matrix mode
        logic [7:0]  opcode;
    } cmdHeader;

    // Host write into the store
    typedef struct packed {
        logic   en;
        cmdAddr addr;
        cmdWord data;
    } memWrite;

    // Four consecutive store words, w0 at the lowest address
    typedef struct packed {
        cmdWord w0;
        cmdWord w1;
        cmdWord w2;
        cmdWord w3;
    } quadRead;

    // Vertex with the color and mode in force when it was parsed
    typedef struct packed {
        logic [7:0] mode;
        cmdWord     r;
        cmdWord     g;
        cmdWord     b;
        cmdWord     x;
        cmdWord     y;
        cmdWord     z;
    } vertexPkt;

    // One row of a loaded matrix
    typedef struct packed {
        logic [7:0] mode;
        logic [1:0] row;  // 0 for the first four words
        cmdWord     c0;
        cmdWord     c1;
        cmdWord     c2;
        cmdWord     c3;
    } matrixRow;

    // Parser state seen by the host
    typedef struct packed {
        logic busy;   // List running
        logic done;   // Last list hit end
        logic error;  // Last list hit an unknown opcode
    } parserStatus;

endpackage
